// File: logic/cmdPkg.sv
package cmdPkg;

    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  regAddr_t;
    typedef logic [3:0]  aluFun_t;
    typedef logic [15:0] wideWord_t;

    localparam byte_t OpWrite = 8'hAA;
    localparam byte_t OpRead  = 8'hBB;
    localparam byte_t OpAlu   = 8'hCC;

    localparam aluFun_t FunAdd  = 4'd0;
    localparam aluFun_t FunSub  = 4'd1;
    localparam aluFun_t FunMul  = 4'd2;
    localparam aluFun_t FunDiv  = 4'd3;
    localparam aluFun_t FunAnd  = 4'd4;
    localparam aluFun_t FunOr   = 4'd5;
    localparam aluFun_t FunNand = 4'd6;
    localparam aluFun_t FunNor  = 4'd7;
    localparam aluFun_t FunXor  = 4'd8;
    localparam aluFun_t FunXnor = 4'd9;
    localparam aluFun_t FunEq   = 4'd10;
    localparam aluFun_t FunGt   = 4'd11;
    localparam aluFun_t FunShr  = 4'd12;
    localparam aluFun_t FunShl  = 4'd13;

    typedef struct packed {
        aluFun_t   fun;
        wideWord_t value;
    } aluResult_t;

    typedef struct packed {
        regAddr_t addr;
        byte_t    data;
    } regWrite_t;

    typedef enum logic [2:0] {
        Idle,
        GetAddr,
        GetData,
        GetFun,
        Issue,
        IssueAlu
    } ctrlState_t;

    typedef enum logic [1:0] {
        PaceIdle,
        PaceWait,
        PaceGap
    } pacerState_t;

    // Arithmetic codes give a two-byte result.
    function automatic logic isArith(aluFun_t fun);
        return fun[3:2] == 2'b00;
    endfunction

endpackage

// File: logic/cmdController.sv
`timescale 1ns/1ps

module cmdController import cmdPkg::*; (
    input  logic      CLK,
    input  logic      Reset,
    input  byte_t     cmdByte,
    input  logic      cmdStrobe,
    input  logic      hasRoom,
    output logic      cmdReady,
    output logic      regWr,
    output regWrite_t regWrData,
    output logic      regRd,
    output regAddr_t  regRdAddr,
    output logic      aluStart,
    output aluFun_t   aluFun
);

    ctrlState_t state;
    logic       isWrite;    // Pending command is a register write.
    regAddr_t   addrHold;
    aluFun_t    funHold;
    logic       byteIn;

    // Source is stalled only while a result waits for FIFO space.
    assign cmdReady  = (state != Issue) && (state != IssueAlu);
    assign byteIn    = cmdStrobe && cmdReady;
    assign regRdAddr = addrHold;
    assign aluFun    = funHold;

    always_ff @(posedge CLK or negedge Reset) begin
        if (!Reset) begin
            state    <= Idle;
            isWrite  <= 1'b0;
            regWr    <= 1'b0;
            regRd    <= 1'b0;
            aluStart <= 1'b0;
        end else begin
            regWr    <= 1'b0;    // Strobes are single pulses.
            regRd    <= 1'b0;
            aluStart <= 1'b0;
            case (state)
                Idle: begin
                    if (byteIn) begin
                        if (cmdByte == OpWrite || cmdByte == OpRead) begin
                            isWrite <= (cmdByte == OpWrite);
                            state   <= GetAddr;
                        end else if (cmdByte == OpAlu) begin
                            state <= GetFun;
                        end
                    end
                end
                GetAddr: begin
                    if (byteIn) begin
                        state <= isWrite ? GetData : Issue;
                    end
                end
                GetData: begin
                    if (byteIn) begin
                        regWr <= 1'b1;
                        state <= Idle;
                    end
                end
                GetFun: begin
                    if (byteIn) begin
                        state <= IssueAlu;
                    end
                end
                Issue: begin
                    if (hasRoom) begin
                        regRd <= 1'b1;
                        state <= Idle;
                    end
                end
                IssueAlu: begin
                    if (hasRoom) begin
                        aluStart <= 1'b1;
                        state    <= Idle;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // Operand capture.
    always_ff @(posedge CLK) begin
        if (byteIn && state == GetAddr) begin
            addrHold <= cmdByte[3:0];
        end
        if (byteIn && state == GetData) begin
            regWrData <= '{addr: addrHold, data: cmdByte};
        end
        if (byteIn && state == GetFun) begin
            funHold <= cmdByte[3:0];
        end
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile import cmdPkg::*; (
    input  logic      CLK,
    input  logic      Reset,
    input  logic      regWr,
    input  regWrite_t regWrData,
    input  logic      regRd,
    input  regAddr_t  regRdAddr,
    output byte_t     rdByte,
    output logic      rdValid,
    output byte_t     operandA,
    output byte_t     operandB
);

    localparam int RegCount = 2 ** $bits(regAddr_t);

    byte_t regs [RegCount];

    // ALU operands are wired straight from the bank.
    assign operandA = regs[0];
    assign operandB = regs[1];

    always_ff @(posedge CLK or negedge Reset) begin
        if (!Reset) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
            rdByte  <= '0;
            rdValid <= 1'b0;
        end else begin
            rdValid <= regRd;
            if (regWr) begin
                regs[regWrData.addr] <= regWrData.data;
            end
            if (regRd) begin
                rdByte <= regs[regRdAddr];    // One-cycle read.
            end
        end
    end

endmodule

// File: logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import cmdPkg::*; (
    input  logic       CLK,
    input  logic       Reset,
    input  logic       aluStart,
    input  aluFun_t    aluFun,
    input  byte_t      operandA,
    input  byte_t      operandB,
    output aluResult_t aluOut,
    output logic       aluValid
);

    wideWord_t wideA;
    wideWord_t wideB;
    wideWord_t result;

    assign wideA = {8'h00, operandA};
    assign wideB = {8'h00, operandB};

    always_comb begin
        case (aluFun)
            FunAdd:  result = wideA + wideB;
            FunSub:  result = wideA - wideB;    // Wraps to 16 bits.
            FunMul:  result = wideA * wideB;
            FunDiv:  result = (operandB == 8'h00) ? '0 : wideA / wideB;
            FunAnd:  result = {8'h00, operandA & operandB};
            FunOr:   result = {8'h00, operandA | operandB};
            FunNand: result = {8'h00, ~(operandA & operandB)};
            FunNor:  result = {8'h00, ~(operandA | operandB)};
            FunXor:  result = {8'h00, operandA ^ operandB};
            FunXnor: result = {8'h00, ~(operandA ^ operandB)};
            FunEq:   result = {15'd0, operandA == operandB};
            FunGt:   result = {15'd0, operandA > operandB};
            FunShr:  result = {8'h00, operandA >> 1};
            FunShl:  result = {8'h00, operandA << 1};    // Top bit drops out.
            default: result = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge Reset) begin
        if (!Reset) begin
            aluValid <= 1'b0;
        end else begin
            aluValid <= aluStart;
        end
    end

    always_ff @(posedge CLK) begin
        if (aluStart) begin
            aluOut <= '{fun: aluFun, value: result};
        end
    end

endmodule

// File: logic/resultFifo.sv
`timescale 1ns/1ps

module resultFifo import cmdPkg::*; #(
    parameter int FifoDepth = 8
) (
    input  logic       CLK,
    input  logic       Reset,
    input  logic       aluValid,
    input  aluResult_t aluOut,
    input  logic       rdValid,
    input  byte_t      rdByte,
    input  logic       readEn,
    output logic       empty,
    output logic       hasRoom,
    output byte_t      outByte,
    output logic       outValid
);

    localparam int AddrW = $clog2(FifoDepth);

    typedef logic [AddrW:0]   ptr_t;
    typedef logic [AddrW-1:0] index_t;

    localparam ptr_t RoomLimit = ptr_t'(FifoDepth - 2);

    byte_t  mem [FifoDepth];
    ptr_t   wrPtr;
    ptr_t   rdPtr;
    ptr_t   used;
    index_t wrIdx;
    index_t wrIdxNext;
    logic   writing;
    logic   twoBytes;
    logic   doRead;

    assign used      = wrPtr - rdPtr;    // Wrap bit keeps full apart from empty.
    assign empty     = (wrPtr == rdPtr);
    assign hasRoom   = (used <= RoomLimit);
    assign wrIdx     = wrPtr[AddrW-1:0];
    assign wrIdxNext = wrIdx + 1'b1;
    assign writing   = aluValid || rdValid;
    assign twoBytes  = aluValid && isArith(aluOut.fun);
    assign doRead    = readEn && !empty && !writing;    // Writes win.

    always_ff @(posedge CLK) begin
        if (aluValid) begin
            mem[wrIdx] <= aluOut.value[7:0];    // Low byte first.
            if (twoBytes) begin
                mem[wrIdxNext] <= aluOut.value[15:8];
            end
        end else if (rdValid) begin
            mem[wrIdx] <= rdByte;
        end
    end

    always_ff @(posedge CLK or negedge Reset) begin
        if (!Reset) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= doRead;
            if (writing) begin
                wrPtr <= wrPtr + (twoBytes ? ptr_t'(2) : ptr_t'(1));
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (doRead) begin
            outByte <= mem[rdPtr[AddrW-1:0]];
        end
    end

endmodule

// File: logic/bytePacer.sv
`timescale 1ns/1ps

module bytePacer import cmdPkg::*; #(
    parameter int GapCycles = 10
) (
    input  logic CLK,
    input  logic Reset,
    input  logic outValid,
    output logic readEn
);

    localparam int CountW = $clog2(GapCycles + 1);

    typedef logic [CountW-1:0] gapCount_t;

    pacerState_t state;
    gapCount_t   count;

    always_ff @(posedge CLK or negedge Reset) begin
        if (!Reset) begin
            state  <= PaceIdle;
            readEn <= 1'b0;
            count  <= '0;
        end else begin
            case (state)
                PaceIdle: begin
                    readEn <= 1'b1;
                    state  <= PaceWait;
                end
                PaceWait: begin
                    if (readEn) begin
                        readEn <= 1'b0;    // Byte shows up next cycle.
                    end else if (outValid) begin
                        count <= gapCount_t'(GapCycles);
                        state <= PaceGap;
                    end else begin
                        state <= PaceIdle;    // Nothing served, retry.
                    end
                end
                PaceGap: begin
                    if (count == gapCount_t'(1)) begin
                        state <= PaceIdle;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    state <= PaceIdle;
                end
            endcase
        end
    end

endmodule

// File: logic/cmdSystemTop.sv
`timescale 1ns/1ps

module cmdSystemTop import cmdPkg::*; #(
    parameter int FifoDepth = 8,
    parameter int GapCycles = 10
) (
    input  logic  CLK,
    input  logic  Reset,
    input  byte_t cmdByte,
    input  logic  cmdStrobe,
    output logic  cmdReady,
    output byte_t outByte,
    output logic  outValid
);

    logic       hasRoom;
    logic       regWr;
    regWrite_t  regWrData;
    logic       regRd;
    regAddr_t   regRdAddr;
    logic       aluStart;
    aluFun_t    aluFun;
    byte_t      rdByte;
    logic       rdValid;
    byte_t      operandA;
    byte_t      operandB;
    aluResult_t aluOut;
    logic       aluValid;
    logic       readEn;

    cmdController iController (
        .CLK       (CLK),
        .Reset     (Reset),
        .cmdByte   (cmdByte),
        .cmdStrobe (cmdStrobe),
        .hasRoom   (hasRoom),
        .cmdReady  (cmdReady),
        .regWr     (regWr),
        .regWrData (regWrData),
        .regRd     (regRd),
        .regRdAddr (regRdAddr),
        .aluStart  (aluStart),
        .aluFun    (aluFun)
    );

    regFile iRegFile (
        .CLK       (CLK),
        .Reset     (Reset),
        .regWr     (regWr),
        .regWrData (regWrData),
        .regRd     (regRd),
        .regRdAddr (regRdAddr),
        .rdByte    (rdByte),
        .rdValid   (rdValid),
        .operandA  (operandA),
        .operandB  (operandB)
    );

    aluUnit iAlu (
        .CLK      (CLK),
        .Reset    (Reset),
        .aluStart (aluStart),
        .aluFun   (aluFun),
        .operandA (operandA),
        .operandB (operandB),
        .aluOut   (aluOut),
        .aluValid (aluValid)
    );

    resultFifo #(
        .FifoDepth (FifoDepth)
    ) iFifo (
        .CLK      (CLK),
        .Reset    (Reset),
        .aluValid (aluValid),
        .aluOut   (aluOut),
        .rdValid  (rdValid),
        .rdByte   (rdByte),
        .readEn   (readEn),
        .empty    (),
        .hasRoom  (hasRoom),
        .outByte  (outByte),
        .outValid (outValid)
    );

    bytePacer #(
        .GapCycles (GapCycles)
    ) iPacer (
        .CLK      (CLK),
        .Reset    (Reset),
        .outValid (outValid),
        .readEn   (readEn)
    );

endmodule

// File: verif/cmdSystemTb.sv
`timescale 1ns/1ps

module cmdSystemTb import cmdPkg::*; ();

    localparam int FifoDepth    = 8;
    localparam int GapCycles    = 10;
    localparam int ResetCycles  = 5;
    localparam int ReadyTimeout = 200;
    localparam int DrainTimeout = 2000;

    typedef struct packed {
        byte_t      op;
        byte_t      arg1;
        byte_t      arg2;
        logic [1:0] byteCount;
    } cmdEntry_t;

    logic  CLK;
    logic  Reset;
    byte_t cmdByte;
    logic  cmdStrobe;
    logic  cmdReady;
    byte_t outByte;
    logic  outValid;

    cmdEntry_t cmdTable [$];
    byte_t     expQueue [$];
    byte_t     regModel [16];
    byte_t     expected;
    integer    seed = 32;
    int        errors = 0;
    int        mismatches = 0;
    int        checked = 0;
    int        burstStart = 0;
    int        lowRun = 0;
    logic      inBurst = 1'b0;
    logic      sawStall = 1'b0;
    logic      aborted = 1'b0;

    cmdSystemTop #(
        .FifoDepth (FifoDepth),
        .GapCycles (GapCycles)
    ) i_dut (
        .CLK       (CLK),
        .Reset     (Reset),
        .cmdByte   (cmdByte),
        .cmdStrobe (cmdStrobe),
        .cmdReady  (cmdReady),
        .outByte   (outByte),
        .outValid  (outValid)
    );

    always #4 CLK = ~CLK;

    function automatic byte_t nextRandomByte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Expected ALU value from the function code rules.
    function automatic logic [15:0] modelAlu(input aluFun_t fun, input byte_t a, input byte_t b);
        logic [15:0] wa;
        logic [15:0] wb;
        wa = {8'h00, a};
        wb = {8'h00, b};
        case (fun)
            4'd0:    return wa + wb;
            4'd1:    return wa - wb;
            4'd2:    return wa * wb;
            4'd3:    return (b == 8'h00) ? 16'h0000 : wa / wb;
            4'd4:    return {8'h00, a & b};
            4'd5:    return {8'h00, a | b};
            4'd6:    return {8'h00, ~(a & b)};
            4'd7:    return {8'h00, ~(a | b)};
            4'd8:    return {8'h00, a ^ b};
            4'd9:    return {8'h00, ~(a ^ b)};
            4'd10:   return (a == b) ? 16'h0001 : 16'h0000;
            4'd11:   return (a > b) ? 16'h0001 : 16'h0000;
            4'd12:   return {9'h000, a[7:1]};
            4'd13:   return {8'h00, a[6:0], 1'b0};
            default: return 16'h0000;
        endcase
    endfunction

    task automatic addCmd(input byte_t op, input byte_t arg1, input byte_t arg2,
                          input logic [1:0] byteCount);
        cmdEntry_t entry;
        entry = '{op: op, arg1: arg1, arg2: arg2, byteCount: byteCount};
        cmdTable.push_back(entry);
    endtask

    task automatic buildTable();
        regAddr_t addrs [4];
        byte_t    aVal;
        byte_t    rdAddr;
        aluFun_t  fun;
        addCmd(OpRead, 8'h00, 8'h00, 2'd1);    // Reset values.
        addCmd(OpRead, 8'h05, 8'h00, 2'd1);
        addCmd(OpRead, 8'h0F, 8'h00, 2'd1);
        for (int i = 0; i < 4; i++) begin
            addrs[i] = regAddr_t'(nextRandomByte());
            addCmd(OpWrite, {4'h0, addrs[i]}, nextRandomByte(), 2'd0);
        end
        for (int i = 0; i < 4; i++) begin
            addCmd(OpRead, {4'h0, addrs[i]}, 8'h00, 2'd1);
        end
        aVal = nextRandomByte();
        addCmd(OpWrite, 8'h00, aVal, 2'd0);
        addCmd(OpWrite, 8'h01, nextRandomByte(), 2'd0);
        addCmd(OpAlu, {4'h0, FunAdd}, 8'h00, 2'd2);
        addCmd(OpAlu, {4'h0, FunSub}, 8'h00, 2'd2);
        addCmd(OpAlu, {4'h0, FunMul}, 8'h00, 2'd2);
        addCmd(OpWrite, 8'h01, 8'h00, 2'd0);    // Divide by zero.
        addCmd(OpAlu, {4'h0, FunDiv}, 8'h00, 2'd2);
        addCmd(OpWrite, 8'h01, nextRandomByte() | 8'h01, 2'd0);
        addCmd(OpAlu, {4'h0, FunDiv}, 8'h00, 2'd2);
        for (int f = 4; f < 16; f++) begin
            fun = aluFun_t'(f);
            addCmd(OpAlu, {4'h0, fun}, 8'h00, 2'd1);
        end
        addCmd(OpWrite, 8'h01, aVal, 2'd0);    // Equal operands.
        addCmd(OpAlu, {4'h0, FunEq}, 8'h00, 2'd1);
        addCmd(OpAlu, {4'h0, FunGt}, 8'h00, 2'd1);
        burstStart = cmdTable.size();
        for (int i = 0; i < 6; i++) begin
            rdAddr = nextRandomByte();
            addCmd(OpRead, {4'h0, rdAddr[3:0]}, 8'h00, 2'd1);
            addCmd(OpAlu, {4'h0, FunMul}, 8'h00, 2'd2);
        end
    endtask

    task automatic modelCommand(input cmdEntry_t cmd);
        logic [15:0] value;
        value = 16'h0000;
        if (cmd.op == OpWrite) begin
            regModel[cmd.arg1[3:0]] = cmd.arg2;
        end else if (cmd.op == OpRead) begin
            value = {8'h00, regModel[cmd.arg1[3:0]]};
        end else if (cmd.op == OpAlu) begin
            value = modelAlu(cmd.arg1[3:0], regModel[0], regModel[1]);
        end
        if (cmd.byteCount != 2'd0) begin
            expQueue.push_back(value[7:0]);
        end
        if (cmd.byteCount == 2'd2) begin
            expQueue.push_back(value[15:8]);    // High byte follows.
        end
    endtask

    // Called 1 ns after a rising edge.
    task automatic sendByte(input byte_t value);
        int waited;
        waited = 0;
        while (!cmdReady && waited < ReadyTimeout) begin
            @(posedge CLK);
            #1;
            waited++;
        end
        if (!cmdReady) begin
            errors++;
            aborted = 1'b1;
            $display("ERROR: cmdReady stayed low for %0d cycles with byte %h waiting",
                     ReadyTimeout, value);
        end else begin
            cmdByte   = value;
            cmdStrobe = 1'b1;
            @(posedge CLK);
            #1;
            cmdStrobe = 1'b0;
        end
    endtask

    task automatic sendCommand(input cmdEntry_t cmd);
        modelCommand(cmd);
        sendByte(cmd.op);
        if (!aborted) begin
            sendByte(cmd.arg1);
        end
        if (!aborted && cmd.op == OpWrite) begin
            sendByte(cmd.arg2);
        end
    endtask

    always @(negedge CLK) begin
        if (Reset && outValid) begin
            if (expQueue.size() == 0) begin
                errors++;
                $display("ERROR: extra output byte %h arrived with nothing expected", outByte);
            end else begin
                expected = expQueue.pop_front();
                checked++;
                if (outByte !== expected) begin
                    mismatches++;
                    $display("MISMATCH outByte expected %h actual %h", expected, outByte);
                end
            end
        end
    end

    // A single low cycle is the normal Issue state.
    always @(negedge CLK) begin
        if (inBurst && !cmdReady) begin
            lowRun++;
        end else begin
            lowRun = 0;
        end
        if (lowRun >= 2) begin
            sawStall = 1'b1;
        end
    end

    initial begin
        int waited;
        CLK       = 1'b0;
        Reset     = 1'b0;
        cmdByte   = 8'h00;
        cmdStrobe = 1'b0;
        for (int i = 0; i < 16; i++) begin
            regModel[i] = 8'h00;
        end
        buildTable();
        repeat (ResetCycles) @(posedge CLK);
        #1;
        Reset = 1'b1;
        if (outValid !== 1'b0) begin
            mismatches++;
            $display("MISMATCH outValid expected %h actual %h", 1'b0, outValid);
        end
        if (cmdReady !== 1'b1) begin
            mismatches++;
            $display("MISMATCH cmdReady expected %h actual %h", 1'b1, cmdReady);
        end
        for (int i = 0; i < cmdTable.size(); i++) begin
            if (!aborted) begin
                if (i == burstStart) begin
                    inBurst = 1'b1;
                end
                sendCommand(cmdTable[i]);
            end
        end
        inBurst = 1'b0;
        if (!aborted && !sawStall) begin
            errors++;
            $display("ERROR: cmdReady never stalled during the command burst");
        end
        waited = 0;
        while (expQueue.size() != 0 && waited < DrainTimeout) begin
            @(posedge CLK);
            waited++;
        end
        if (expQueue.size() != 0) begin
            errors++;
            $display("ERROR: timed out with %0d result bytes still missing", expQueue.size());
        end else begin
            repeat (3 * (GapCycles + 2)) @(posedge CLK);    // Catch stray bytes.
        end
        $display("Summary: %0d mismatches, %0d other errors, %0d bytes checked",
                 mismatches, errors, checked);
        if (mismatches == 0 && errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src.f
logic/cmdPkg.sv
logic/cmdController.sv
logic/regFile.sv
logic/aluUnit.sv
logic/resultFifo.sv
logic/bytePacer.sv
logic/cmdSystemTop.sv
verif/cmdSystemTb.sv

// File: Makefile
# Verilator build and run for the command subsystem testbench.

VERILATOR ?= verilator
TOP       ?= cmdSystemTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Result: PASS" || \
		(echo "Result: FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
